// File: hdl/renameCfg_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Lanes renamed per group.
`define RENAME_WIDTH 2

`define ARCH_REGS 8
`define PHYS_REGS 24

// Registers not holding an architectural mapping at reset.
`define FREE_LIST_SIZE (`PHYS_REGS - `ARCH_REGS)

`define ARCH_TAG_W 3
`define PHYS_TAG_W 5
`define FREE_PTR_W 4
`define FREE_CNT_W 5

`endif

// File: hdl/renamePkg.sv
`include "renameCfg_cfg.svh"

package renamePkg;

  // Architectural register number.
  typedef logic [`ARCH_TAG_W-1:0] archTagT;

  // Physical register number.
  typedef logic [`PHYS_TAG_W-1:0] physTagT;

  // Free entries, 0 up to the full list size.
  typedef logic [`FREE_CNT_W-1:0] freeCountT;

endpackage

// File: hdl/ctrlPkg.sv
package ctrlPkg;

  typedef enum logic [1:0] {
    CMD_RENAME     = 2'd0,
    CMD_COMMIT     = 2'd1,
    CMD_CHECKPOINT = 2'd2,
    CMD_RECOVER    = 2'd3
  } cmdKindE;

  // Lane valids sit in the same bits in both views.
  typedef struct packed {
    logic               valid1;
    logic               valid0;
    renamePkg::archTagT dest1;
    renamePkg::archTagT dest0;
    logic [3:0]         pad;
  } renameCmdT;

  typedef struct packed {
    logic               valid1;
    logic               valid0;
    renamePkg::physTagT rel1;
    renamePkg::physTagT rel0;
  } commitCmdT;

  // Read as rename or commit by the command kind.
  typedef union packed {
    renameCmdT rename;
    commitCmdT commit;
  } cmdWordU;

endpackage

// File: hdl/specFreeList.sv
`timescale 1ns/1ps
`include "renameCfg_cfg.svh"

module specFreeList (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 allocate_i,
  input  logic                 release_i,
  input  logic                 checkpoint_i,
  input  logic                 recover_i,
  input  logic                 laneValid0_i,
  input  logic                 laneValid1_i,
  input  renamePkg::physTagT   relTag0_i,
  input  renamePkg::physTagT   relTag1_i,
  output renamePkg::physTagT   allocTag0_o,
  output renamePkg::physTagT   allocTag1_o,
  output logic                 enoughFree_o,
  output renamePkg::freeCountT freeCount_o
);

  renamePkg::physTagT   freeMem [`FREE_LIST_SIZE];
  logic [`FREE_PTR_W-1:0] head;
  logic [`FREE_PTR_W-1:0] tail;
  logic [`FREE_PTR_W-1:0] headCp;
  logic [`FREE_PTR_W-1:0] headNext;
  logic [`FREE_PTR_W-1:0] tailNext;
  renamePkg::freeCountT count;
  renamePkg::freeCountT countCp;
  renamePkg::freeCountT pushSinceCp;
  logic [1:0]           popNum;
  logic [1:0]           pushNum;
  renamePkg::physTagT   relFirst;

  // Pointer advance with wrap at the list size.
  function automatic logic [`FREE_PTR_W-1:0] wrapAdd(input logic [`FREE_PTR_W-1:0] ptr,
                                                     input logic [1:0] inc);
    logic [`FREE_PTR_W:0] sum;
    sum = ptr + (`FREE_PTR_W+1)'(inc);
    if (sum >= (`FREE_PTR_W+1)'(`FREE_LIST_SIZE)) begin
      sum = sum - (`FREE_PTR_W+1)'(`FREE_LIST_SIZE);
    end
    return sum[`FREE_PTR_W-1:0];
  endfunction

  assign headNext = wrapAdd(head, 2'd1);
  assign tailNext = wrapAdd(tail, 2'd1);

  assign allocTag0_o  = freeMem[head];
  assign allocTag1_o  = freeMem[headNext];
  assign enoughFree_o = count >= renamePkg::freeCountT'(`RENAME_WIDTH);
  assign freeCount_o  = count;

  assign popNum  = allocate_i ? 2'(laneValid0_i) + 2'(laneValid1_i) : 2'd0;
  assign pushNum = release_i ? 2'(laneValid0_i) + 2'(laneValid1_i) : 2'd0;

  // First valid release lane goes to the tail.
  assign relFirst = laneValid0_i ? relTag0_i : relTag1_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      head        <= '0;
      tail        <= '0;
      headCp      <= '0;
      count       <= renamePkg::freeCountT'(`FREE_LIST_SIZE);
      countCp     <= renamePkg::freeCountT'(`FREE_LIST_SIZE);
      pushSinceCp <= '0;
      for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
        freeMem[i] <= renamePkg::physTagT'(`ARCH_REGS + i);
      end
    end else begin
      if (recover_i) begin
        // Tail is kept, so commits since the checkpoint stay free.
        head  <= headCp;
        count <= countCp + pushSinceCp;
      end else begin
        head  <= wrapAdd(head, popNum);
        count <= count - renamePkg::freeCountT'(popNum) + renamePkg::freeCountT'(pushNum);
      end
      tail <= wrapAdd(tail, pushNum);
      if (checkpoint_i) begin
        headCp      <= head;
        countCp     <= count;
        pushSinceCp <= '0;
      end else begin
        pushSinceCp <= pushSinceCp + renamePkg::freeCountT'(pushNum);
      end
      if (release_i && (laneValid0_i || laneValid1_i)) begin
        freeMem[tail] <= relFirst;
      end
      if (release_i && laneValid0_i && laneValid1_i) begin
        freeMem[tailNext] <= relTag1_i;
      end
    end
  end

  countBound: assert property (@(posedge clk) disable iff (reset)
    freeCount_o <= renamePkg::freeCountT'(`FREE_LIST_SIZE));

  // The control must refuse short groups before they reach the list.
  noAllocWhenShort: assert property (@(posedge clk) disable iff (reset)
    allocate_i |-> enoughFree_o);

endmodule

// File: hdl/renameMapTable.sv
`timescale 1ns/1ps
`include "renameCfg_cfg.svh"

module renameMapTable (
  input  logic               clk,
  input  logic               reset,
  input  logic               allocate_i,
  input  logic               checkpoint_i,
  input  logic               recover_i,
  input  logic               laneValid0_i,
  input  logic               laneValid1_i,
  input  renamePkg::archTagT destArch0_i,
  input  renamePkg::archTagT destArch1_i,
  input  renamePkg::physTagT newTag0_i,
  input  renamePkg::physTagT newTag1_i,
  output renamePkg::physTagT prevTag0_o,
  output renamePkg::physTagT prevTag1_o
);

  renamePkg::physTagT mapTable [`ARCH_REGS];
  renamePkg::physTagT mapCp    [`ARCH_REGS];
  renamePkg::physTagT lane1New;
  logic               sameDest;

  // Lane 1 takes the head entry when lane 0 is empty.
  assign lane1New = laneValid0_i ? newTag1_i : newTag0_i;

  assign sameDest = laneValid0_i && laneValid1_i && (destArch0_i == destArch1_i);

  assign prevTag0_o = mapTable[destArch0_i];
  // Forward lane 0's new mapping within the group.
  assign prevTag1_o = sameDest ? newTag0_i : mapTable[destArch1_i];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        mapTable[i] <= renamePkg::physTagT'(i);
        mapCp[i]    <= renamePkg::physTagT'(i);
      end
    end else begin
      if (recover_i) begin
        for (int i = 0; i < `ARCH_REGS; i++) begin
          mapTable[i] <= mapCp[i];
        end
      end else if (allocate_i) begin
        if (laneValid0_i) begin
          mapTable[destArch0_i] <= newTag0_i;
        end
        // Later write wins on a shared destination.
        if (laneValid1_i) begin
          mapTable[destArch1_i] <= lane1New;
        end
      end
      if (checkpoint_i) begin
        for (int i = 0; i < `ARCH_REGS; i++) begin
          mapCp[i] <= mapTable[i];
        end
      end
    end
  end

endmodule

// File: hdl/renameCtrl.sv
`timescale 1ns/1ps
`include "renameCfg_cfg.svh"

module renameCtrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_i,
  input  ctrlPkg::cmdKindE     cmdKind_i,
  input  ctrlPkg::cmdWordU     cmdWord_i,
  input  renamePkg::physTagT   allocTag0_i,
  input  renamePkg::physTagT   allocTag1_i,
  input  renamePkg::physTagT   prevTag0_i,
  input  renamePkg::physTagT   prevTag1_i,
  input  logic                 enoughFree_i,
  input  renamePkg::freeCountT freeCount_i,
  output logic                 ack_o,
  output logic                 allocate_o,
  output logic                 release_o,
  output logic                 checkpoint_o,
  output logic                 recover_o,
  output logic                 laneValid0_o,
  output logic                 laneValid1_o,
  output renamePkg::archTagT   destArch0_o,
  output renamePkg::archTagT   destArch1_o,
  output renamePkg::physTagT   relTag0_o,
  output renamePkg::physTagT   relTag1_o,
  output renamePkg::physTagT   physTag0_o,
  output renamePkg::physTagT   physTag1_o,
  output renamePkg::physTagT   prevTag0_o,
  output renamePkg::physTagT   prevTag1_o,
  output logic                 allocOk_o,
  output renamePkg::freeCountT freeCount_o
);

  typedef enum logic {ST_IDLE, ST_ACK} stateE;

  stateE              state;
  logic               accept;
  logic               isRename;
  logic               laneOk0;
  logic               laneOk1;
  renamePkg::physTagT lane1Alloc;

  assign accept   = (state == ST_IDLE) && req_i;
  assign isRename = cmdKind_i == ctrlPkg::CMD_RENAME;

  // One strobe per accepted command.
  assign allocate_o   = accept && isRename && enoughFree_i;
  assign release_o    = accept && (cmdKind_i == ctrlPkg::CMD_COMMIT);
  assign checkpoint_o = accept && (cmdKind_i == ctrlPkg::CMD_CHECKPOINT);
  assign recover_o    = accept && (cmdKind_i == ctrlPkg::CMD_RECOVER);

  assign laneValid0_o = cmdWord_i.rename.valid0;
  assign laneValid1_o = cmdWord_i.rename.valid1;
  assign destArch0_o  = cmdWord_i.rename.dest0;
  assign destArch1_o  = cmdWord_i.rename.dest1;
  assign relTag0_o    = cmdWord_i.commit.rel0;
  assign relTag1_o    = cmdWord_i.commit.rel1;

  assign laneOk0    = cmdWord_i.rename.valid0 && enoughFree_i;
  assign laneOk1    = cmdWord_i.rename.valid1 && enoughFree_i;
  assign lane1Alloc = cmdWord_i.rename.valid0 ? allocTag1_i : allocTag0_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      ack_o       <= 1'b0;
      physTag0_o  <= '0;
      physTag1_o  <= '0;
      prevTag0_o  <= '0;
      prevTag1_o  <= '0;
      allocOk_o   <= 1'b0;
      freeCount_o <= renamePkg::freeCountT'(`FREE_LIST_SIZE);
    end else begin
      ack_o <= (state == ST_ACK) && req_i;
      case (state)
        ST_IDLE: begin
          if (req_i) begin
            state <= ST_ACK;
            if (isRename) begin
              physTag0_o <= laneOk0 ? allocTag0_i : '0;
              physTag1_o <= laneOk1 ? lane1Alloc : '0;
              prevTag0_o <= laneOk0 ? prevTag0_i : '0;
              prevTag1_o <= laneOk1 ? prevTag1_i : '0;
              allocOk_o  <= enoughFree_i;
            end
          end
        end
        ST_ACK: begin
          // Count has settled by the edge that raises ack.
          if (!ack_o) begin
            freeCount_o <= freeCount_i;
          end
          if (!req_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack_o) |-> $past(req_i));

  oneStrobe: assert property (@(posedge clk) disable iff (reset)
    $onehot0({allocate_o, release_o, checkpoint_o, recover_o}));

endmodule

// File: hdl/renameTop.sv
`timescale 1ns/1ps

module renameTop (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_i,
  input  ctrlPkg::cmdKindE     cmdKind_i,
  input  ctrlPkg::cmdWordU     cmdWord_i,
  output logic                 ack_o,
  output renamePkg::physTagT   physTag0_o,
  output renamePkg::physTagT   physTag1_o,
  output renamePkg::physTagT   prevTag0_o,
  output renamePkg::physTagT   prevTag1_o,
  output logic                 allocOk_o,
  output renamePkg::freeCountT freeCount_o
);

  logic                 allocate;
  logic                 releaseRegs;
  logic                 checkpoint;
  logic                 recover;
  logic                 laneValid0;
  logic                 laneValid1;
  logic                 enoughFree;
  renamePkg::archTagT   destArch0;
  renamePkg::archTagT   destArch1;
  renamePkg::physTagT   relTag0;
  renamePkg::physTagT   relTag1;
  renamePkg::physTagT   allocTag0;
  renamePkg::physTagT   allocTag1;
  renamePkg::physTagT   prevTag0;
  renamePkg::physTagT   prevTag1;
  renamePkg::freeCountT freeCount;

  renameCtrl ctrl (
    .clk(clk), .reset(reset), .req_i(req_i), .cmdKind_i(cmdKind_i), .cmdWord_i(cmdWord_i),
    .allocTag0_i(allocTag0), .allocTag1_i(allocTag1),
    .prevTag0_i(prevTag0), .prevTag1_i(prevTag1),
    .enoughFree_i(enoughFree), .freeCount_i(freeCount), .ack_o(ack_o),
    .allocate_o(allocate), .release_o(releaseRegs),
    .checkpoint_o(checkpoint), .recover_o(recover),
    .laneValid0_o(laneValid0), .laneValid1_o(laneValid1),
    .destArch0_o(destArch0), .destArch1_o(destArch1),
    .relTag0_o(relTag0), .relTag1_o(relTag1),
    .physTag0_o(physTag0_o), .physTag1_o(physTag1_o),
    .prevTag0_o(prevTag0_o), .prevTag1_o(prevTag1_o),
    .allocOk_o(allocOk_o), .freeCount_o(freeCount_o)
  );

  specFreeList freeList (
    .clk(clk), .reset(reset), .allocate_i(allocate), .release_i(releaseRegs),
    .checkpoint_i(checkpoint), .recover_i(recover),
    .laneValid0_i(laneValid0), .laneValid1_i(laneValid1),
    .relTag0_i(relTag0), .relTag1_i(relTag1),
    .allocTag0_o(allocTag0), .allocTag1_o(allocTag1),
    .enoughFree_o(enoughFree), .freeCount_o(freeCount)
  );

  // Head entries feed the map; lane compaction happens inside.
  renameMapTable mapTable (
    .clk(clk), .reset(reset), .allocate_i(allocate),
    .checkpoint_i(checkpoint), .recover_i(recover),
    .laneValid0_i(laneValid0), .laneValid1_i(laneValid1),
    .destArch0_i(destArch0), .destArch1_i(destArch1),
    .newTag0_i(allocTag0), .newTag1_i(allocTag1),
    .prevTag0_o(prevTag0), .prevTag1_o(prevTag1)
  );

endmodule

// File: test/renameTb.sv
`timescale 1ns/1ps
`include "renameCfg_cfg.svh"

module renameTb;

  // Upper bound on commands issued by all tests together.
  localparam int NUM_CMDS = 60;
  localparam int CLK_PERIOD = 4;

  logic                 clk;
  logic                 reset;
  logic                 req;
  ctrlPkg::cmdKindE     cmdKind;
  ctrlPkg::cmdWordU     cmdWord;
  logic                 ack;
  renamePkg::physTagT   physTag0;
  renamePkg::physTagT   physTag1;
  renamePkg::physTagT   prevTag0;
  renamePkg::physTagT   prevTag1;
  logic                 allocOk;
  renamePkg::freeCountT freeCount;

  // Reference model state.
  renamePkg::physTagT freeQ [$];
  renamePkg::physTagT cpQ [$];
  renamePkg::physTagT pushedQ [$];
  renamePkg::physTagT retireQ [$];
  renamePkg::physTagT mapModel [`ARCH_REGS];
  renamePkg::physTagT mapCp [`ARCH_REGS];
  string              testName;

  renameTop uut (
    .clk(clk), .reset(reset), .req_i(req), .cmdKind_i(cmdKind), .cmdWord_i(cmdWord),
    .ack_o(ack), .physTag0_o(physTag0), .physTag1_o(physTag1),
    .prevTag0_o(prevTag0), .prevTag1_o(prevTag1),
    .allocOk_o(allocOk), .freeCount_o(freeCount)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "run aborted");
  endtask

  task automatic checkTag(input string what, input renamePkg::physTagT expVal,
                          input renamePkg::physTagT actVal);
    if (expVal !== actVal) begin
      abortRun($sformatf("[FAIL] %s: %s expected %0d actual %0d",
                         testName, what, expVal, actVal));
    end
  endtask

  task automatic checkCount(input string what, input renamePkg::freeCountT expVal,
                            input renamePkg::freeCountT actVal);
    if (expVal !== actVal) begin
      abortRun($sformatf("[FAIL] %s: %s expected %0d actual %0d",
                         testName, what, expVal, actVal));
    end
  endtask

  task automatic checkBit(input string what, input logic expVal, input logic actVal);
    if (expVal !== actVal) begin
      abortRun($sformatf("[FAIL] %s: %s expected %b actual %b",
                         testName, what, expVal, actVal));
    end
  endtask

  // One four-phase exchange, called and returning on a falling edge.
  task automatic doCommand(input ctrlPkg::cmdKindE kind, input ctrlPkg::cmdWordU word);
    int waitCycles;
    cmdKind = kind;
    cmdWord = word;
    req = 1'b1;
    waitCycles = 0;
    while (!ack) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles >= 10 && !ack) begin
        abortRun($sformatf("ack_o did not rise within 10 cycles in %s", testName));
      end
    end
    req = 1'b0;
    waitCycles = 0;
    while (ack) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 10) begin
        abortRun($sformatf("ack_o did not fall after req_i dropped in %s", testName));
      end
    end
  endtask

  task automatic renameStep(input logic v0, input logic v1,
                            input renamePkg::archTagT d0, input renamePkg::archTagT d1);
    ctrlPkg::cmdWordU   word;
    logic               ok;
    renamePkg::physTagT exp0;
    renamePkg::physTagT exp1;
    renamePkg::physTagT expPrev0;
    renamePkg::physTagT expPrev1;
    word = '0;
    word.rename.valid0 = v0;
    word.rename.valid1 = v1;
    word.rename.dest0 = d0;
    word.rename.dest1 = d1;
    ok = freeQ.size() >= `RENAME_WIDTH;
    exp0 = '0;
    exp1 = '0;
    expPrev0 = '0;
    expPrev1 = '0;
    // Lanes in order, so a shared destination forwards naturally.
    if (ok) begin
      if (v0) begin
        exp0 = freeQ.pop_front();
        expPrev0 = mapModel[d0];
        mapModel[d0] = exp0;
        retireQ.push_back(expPrev0);
      end
      if (v1) begin
        exp1 = freeQ.pop_front();
        expPrev1 = mapModel[d1];
        mapModel[d1] = exp1;
        retireQ.push_back(expPrev1);
      end
    end
    doCommand(ctrlPkg::CMD_RENAME, word);
    checkBit("allocOk", ok, allocOk);
    checkTag("physTag0", exp0, physTag0);
    checkTag("physTag1", exp1, physTag1);
    checkTag("prevTag0", expPrev0, prevTag0);
    checkTag("prevTag1", expPrev1, prevTag1);
    checkCount("freeCount", renamePkg::freeCountT'(freeQ.size()), freeCount);
  endtask

  task automatic commitStep(input logic v0, input logic v1,
                            input renamePkg::physTagT r0, input renamePkg::physTagT r1);
    ctrlPkg::cmdWordU word;
    word = '0;
    word.commit.valid0 = v0;
    word.commit.valid1 = v1;
    word.commit.rel0 = r0;
    word.commit.rel1 = r1;
    if (v0) begin
      freeQ.push_back(r0);
      pushedQ.push_back(r0);
    end
    if (v1) begin
      freeQ.push_back(r1);
      pushedQ.push_back(r1);
    end
    doCommand(ctrlPkg::CMD_COMMIT, word);
    checkCount("freeCount", renamePkg::freeCountT'(freeQ.size()), freeCount);
  endtask

  task automatic retirePair();
    renamePkg::physTagT tagA;
    renamePkg::physTagT tagB;
    tagA = retireQ.pop_front();
    tagB = retireQ.pop_front();
    commitStep(1'b1, 1'b1, tagA, tagB);
  endtask

  task automatic checkpointStep();
    cpQ = freeQ;
    mapCp = mapModel;
    pushedQ.delete();
    doCommand(ctrlPkg::CMD_CHECKPOINT, '0);
    checkCount("freeCount", renamePkg::freeCountT'(freeQ.size()), freeCount);
  endtask

  // Saved head with everything committed since then appended.
  task automatic recoverStep();
    freeQ = cpQ;
    foreach (pushedQ[i]) begin
      freeQ.push_back(pushedQ[i]);
    end
    mapModel = mapCp;
    doCommand(ctrlPkg::CMD_RECOVER, '0);
    checkCount("freeCount", renamePkg::freeCountT'(freeQ.size()), freeCount);
  endtask

  task automatic resetAllocTest();
    testName = "resetAlloc";
    checkBit("allocOk", 1'b0, allocOk);
    checkTag("physTag0", '0, physTag0);
    checkTag("physTag1", '0, physTag1);
    checkTag("prevTag0", '0, prevTag0);
    checkTag("prevTag1", '0, prevTag1);
    checkCount("freeCount", renamePkg::freeCountT'(`FREE_LIST_SIZE), freeCount);
    renameStep(1'b1, 1'b1, 3'd1, 3'd2);
    renameStep(1'b1, 1'b1, 3'd3, 3'd4);
    renameStep(1'b1, 1'b1, 3'd1, 3'd5);
  endtask

  task automatic compactForwardTest();
    testName = "compactForward";
    renameStep(1'b0, 1'b1, 3'd0, 3'd6);
    renameStep(1'b1, 1'b1, 3'd7, 3'd7);
    renameStep(1'b1, 1'b0, 3'd7, 3'd0);
  endtask

  task automatic releaseWrapTest();
    renamePkg::physTagT tag;
    testName = "releaseWrap";
    repeat (3) retirePair();
    tag = retireQ.pop_front();
    commitStep(1'b0, 1'b1, '0, tag);
    // Walks the head past the end of the array into the released tags.
    for (int i = 0; i < 6; i++) begin
      renameStep(1'b1, 1'b1, renamePkg::archTagT'(i), renamePkg::archTagT'(i + 3));
    end
  endtask

  task automatic refuseShortTest();
    testName = "refuseShort";
    while (freeQ.size() >= `RENAME_WIDTH) begin
      renameStep(1'b1, 1'b1, 3'd2, 3'd4);
    end
    renameStep(1'b1, 1'b0, 3'd5, 3'd0);
    renameStep(1'b1, 1'b1, 3'd5, 3'd6);
    retirePair();
    renameStep(1'b1, 1'b1, 3'd5, 3'd6);
  endtask

  task automatic checkpointRecoverTest();
    logic [31:0] r;
    testName = "checkpointRecover";
    // Several free entries behind the saved head.
    repeat (2) retirePair();
    checkpointStep();
    // Moves the head, changes the map and pushes at least once.
    renameStep(1'b1, 1'b1, 3'd0, 3'd3);
    retirePair();
    repeat (12) begin
      r = $urandom;
      if (r[0] && retireQ.size() >= 2 &&
          cpQ.size() + pushedQ.size() + 2 <= `FREE_LIST_SIZE) begin
        retirePair();
      end else begin
        renameStep(r[1], r[2], r[5:3], r[8:6]);
      end
    end
    recoverStep();
    renameStep(1'b1, 1'b1, 3'd0, 3'd1);
    renameStep(1'b1, 1'b1, 3'd2, 3'd3);
    renameStep(1'b1, 1'b1, 3'd4, 3'd7);
  endtask

  initial begin
    #((NUM_CMDS * 20 + 10) * CLK_PERIOD);
    abortRun($sformatf("Run timed out after %0d cycles", NUM_CMDS * 20 + 10));
  end

  initial begin
    void'($urandom(32'h934cff47));
    clk = 1'b0;
    reset = 1'b1;
    req = 1'b0;
    cmdKind = ctrlPkg::CMD_RENAME;
    cmdWord = '0;
    for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
      freeQ.push_back(renamePkg::physTagT'(`ARCH_REGS + i));
    end
    for (int i = 0; i < `ARCH_REGS; i++) begin
      mapModel[i] = renamePkg::physTagT'(i);
    end
    cpQ = freeQ;
    mapCp = mapModel;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    resetAllocTest();
    compactForwardTest();
    releaseWrapTest();
    refuseShortTest();
    checkpointRecoverTest();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: src.f
+incdir+hdl
hdl/renamePkg.sv
hdl/ctrlPkg.sv
hdl/specFreeList.sv
hdl/renameMapTable.sv
hdl/renameCtrl.sv
hdl/renameTop.sv
test/renameTb.sv
